//--- project.f
common/riscboy_pkg.sv
verilog/ahbl_to_apb.sv
verilog/apb_splitter.sv
gpio/gpio.sv
sys_ctrl/sys_ctrl.sv
verilog/periph_core.sv
test/tb_periph_core.sv

//--- Bender.yml
package:
  name: periph_core

sources:
  - common/riscboy_pkg.sv
  - verilog/ahbl_to_apb.sv
  - verilog/apb_splitter.sv
  - gpio/gpio.sv
  - sys_ctrl/sys_ctrl.sv
  - verilog/periph_core.sv
  - target: test
    files:
      - test/tb_periph_core.sv

//--- test/tb_periph_core.sv
// Testbench for the peripheral subsystem with random AHB-Lite traffic and a register model
`timescale 1ns/1ps

module tb_periph_core;

	import riscboy_pkg::*;

	localparam int N_TRANSFERS    = 400;
	// Worst case is a 4 cycle error plus two idle cycles after a pad change
	localparam int TIMEOUT_CYCLES = N_TRANSFERS * 6 + 100;

	logic              clk;
	logic              reset;
	logic [W_ADDR-1:0] haddr;
	logic              hwrite;
	logic [1:0]        htrans;
	logic [2:0]        hsize;
	logic              hready;
	logic [W_DATA-1:0] hwdata;
	logic              hready_resp;
	logic              hresp;
	logic [W_DATA-1:0] hrdata;
	logic [N_PADS-1:0] pad_in;
	logic [N_PADS-1:0] pad_out;
	logic [N_PADS-1:0] pad_oe;

	// Register model
	logic [W_DATA-1:0] scratch_model [0:3];
	logic [N_PADS-1:0] out_model;
	logic [N_PADS-1:0] dir_model;
	logic [N_PADS-1:0] pad_model;

	logic [31:0] lfsr_state  = 32'he97b_e817;
	int          cycle_count = 0;

	periph_core UUT (
		.clk         (clk),
		.reset       (reset),
		.haddr       (haddr),
		.hwrite      (hwrite),
		.htrans      (htrans),
		.hsize       (hsize),
		.hready      (hready),
		.hwdata      (hwdata),
		.hready_resp (hready_resp),
		.hresp       (hresp),
		.hrdata      (hrdata),
		.pad_in      (pad_in),
		.pad_out     (pad_out),
		.pad_oe      (pad_oe)
	);

	// Lone master on the bus
	assign hready = hready_resp;

	initial clk = 1'b0;
	always #10 clk = ~clk;

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("TEST FAILED");
			$fatal(1, "Timeout after %0d cycles, the transfers did not finish", cycle_count);
		end
	end

	// ========================================================================
	// Helpers
	// ========================================================================

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] val;
		val = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = {1'b0, lfsr_state[31:1]} ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
			val = {val[30:0], lfsr_state[0]};
		end
		return val;
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		$display("error: %0t ns %s expected %h actual %h", $time, name, exp, act);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic report_failure(input string what);
		$display("%s at %0t ns", what, $time);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic check_equal(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp) else report_mismatch(name, exp, act);
	endtask

	// Legal and illegal targets, 9 and 10 sit in unmapped slots
	// while 3 and 11 are unknown offsets inside a mapped slot
	function automatic logic [31:0] target_addr(input int idx);
		logic [15:0] apb;
		case (idx)
			0: apb = {SLOT_GPIO, GPIO_OUT};
			1: apb = {SLOT_GPIO, GPIO_DIR};
			2: apb = {SLOT_GPIO, GPIO_IN};
			3: apb = {SLOT_GPIO, 12'h00C};
			4: apb = {SLOT_SYSCTRL, SYS_ID};
			5, 6, 7, 8: apb = {SLOT_SYSCTRL, SYS_SCRATCH0 + 12'(4 * (idx - 5))};
			9: apb = 16'h2000;
			11: apb = {SLOT_SYSCTRL, 12'h008};
			default: apb = 16'hF004;
		endcase
		return APB_BASE | {16'h0000, apb};
	endfunction

	task automatic change_pads(input logic [N_PADS-1:0] value);
		pad_in    = value;
		pad_model = value;
		// Let the two-flop synchronizer settle
		repeat (2) begin
			@(posedge clk);
			#1;
		end
	endtask

	// ========================================================================
	// One AHB-Lite transfer, entered and left in a cycle with hready_resp high
	// ========================================================================

	task automatic run_transfer(input logic [31:0] addr, input logic wr, input logic [2:0] size,
			input logic [31:0] wdata);
		logic [3:0]  slot;
		logic [11:0] offs;
		logic        exp_err;
		logic [31:0] exp_rdata;
		int          exp_cycles;
		int          cycles;
		slot      = addr[15:12];
		offs      = addr[11:0];
		exp_err   = 1'b0;
		exp_rdata = '0;
		if (size != HSIZE_WORD) begin
			exp_err = 1'b1;
		end else if (slot == SLOT_GPIO) begin
			if (offs == GPIO_OUT) begin
				exp_rdata = {16'h0000, out_model};
				if (wr)
					out_model = wdata[N_PADS-1:0];
			end else if (offs == GPIO_DIR) begin
				exp_rdata = {16'h0000, dir_model};
				if (wr)
					dir_model = wdata[N_PADS-1:0];
			end else if (offs == GPIO_IN && !wr) begin
				exp_rdata = {16'h0000, pad_model};
			end else begin
				exp_err = 1'b1;
			end
		end else if (slot == SLOT_SYSCTRL) begin
			if (offs == SYS_ID && !wr) begin
				exp_rdata = SYS_ID_VALUE;
			end else if (offs >= 12'h010 && offs <= 12'h01C && offs[1:0] == 2'b00) begin
				exp_rdata = scratch_model[offs[3:2]];
				if (wr)
					scratch_model[offs[3:2]] = wdata;
			end else begin
				exp_err = 1'b1;
			end
		end else begin
			exp_err = 1'b1;
		end
		exp_cycles = (size != HSIZE_WORD) ? 2 : (exp_err ? 4 : 3);

		assert (hready_resp === 1'b1)
		else report_failure("Address phase started while the bridge was not ready");
		haddr  = addr;
		hwrite = wr;
		hsize  = size;
		htrans = HTRANS_NONSEQ;
		@(posedge clk);
		#1;
		cycles = 1;
		hwdata = wdata;
		htrans = HTRANS_IDLE;
		while (hready_resp !== 1'b1) begin
			assert (cycles < exp_cycles) else report_failure("Data phase ran longer than expected");
			// First error cycle has hresp high with hready_resp still low
			check_equal("hresp", exp_err && (cycles == exp_cycles - 1), hresp);
			@(posedge clk);
			#1;
			cycles++;
		end
		check_equal("data phase cycles", exp_cycles, cycles);
		check_equal("hresp", exp_err, hresp);
		if (!wr && !exp_err)
			check_equal("hrdata", exp_rdata, hrdata);
		check_equal("pad_out", out_model, pad_out);
		check_equal("pad_oe", dir_model, pad_oe);
	endtask

	// ========================================================================
	// Stimulus
	// ========================================================================

	initial begin
		logic        wr;
		logic [2:0]  size;
		logic [31:0] wdata;
		int          target;
		reset  = 1'b1;
		haddr  = '0;
		hwrite = 1'b0;
		htrans = HTRANS_IDLE;
		hsize  = HSIZE_WORD;
		hwdata = '0;
		pad_in = '0;
		out_model = '0;
		dir_model = '0;
		pad_model = '0;
		for (int i = 0; i < 4; i++)
			scratch_model[i] = '0;

		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;
		check_equal("hready_resp", 1'b1, hready_resp);
		check_equal("hresp", 1'b0, hresp);
		check_equal("pad_out", '0, pad_out);
		check_equal("pad_oe", '0, pad_oe);

		// Scratch words come up zero, ID is read-only
		for (int i = 0; i < 4; i++)
			run_transfer(target_addr(5 + i), 1'b0, HSIZE_WORD, '0);
		run_transfer(target_addr(4), 1'b0, HSIZE_WORD, '0);
		run_transfer(target_addr(4), 1'b1, HSIZE_WORD, 32'hdead_beef);
		run_transfer(target_addr(4), 1'b0, HSIZE_WORD, '0);

		for (int n = 0; n < N_TRANSFERS; n++) begin
			if (rand_bits(3) == 0)
				change_pads(rand_bits(N_PADS));
			wr     = rand_bits(1);
			target = rand_bits(4) % 12;
			if (rand_bits(3) == 0)
				size = rand_bits(1) ? 3'b000 : 3'b001;
			else
				size = HSIZE_WORD;
			wdata = rand_bits(32);
			run_transfer(target_addr(target), wr, size, wdata);
		end

		$display("TEST OK");
		$finish;
	end

endmodule

//--- verilog/periph_core.sv
// Peripheral subsystem top with AHB-Lite bridge, APB splitter, GPIO and system control
`timescale 1ns/1ps

module periph_core (
	input  logic                            clk,
	input  logic                            reset,
	input  logic [riscboy_pkg::W_ADDR-1:0]  haddr,
	input  logic                            hwrite,
	input  logic [1:0]                      htrans,
	input  logic [2:0]                      hsize,
	input  logic                            hready,
	input  logic [riscboy_pkg::W_DATA-1:0]  hwdata,
	output logic                            hready_resp,
	output logic                            hresp,
	output logic [riscboy_pkg::W_DATA-1:0]  hrdata,
	input  logic [riscboy_pkg::N_PADS-1:0]  pad_in,
	output logic [riscboy_pkg::N_PADS-1:0]  pad_out,
	output logic [riscboy_pkg::N_PADS-1:0]  pad_oe
);

	import riscboy_pkg::*;

	// ========================================================================
	// Interconnect
	// ========================================================================

	// Bridge side of the APB
	logic [W_PADDR-1:0] bridge_paddr;
	logic               bridge_psel;
	logic               bridge_penable;
	logic               bridge_pwrite;
	logic [W_DATA-1:0]  bridge_pwdata;
	logic [W_DATA-1:0]  bridge_prdata;
	logic               bridge_pready;
	logic               bridge_pslverr;

	// Peripheral sides
	logic               gpio_psel;
	logic [W_DATA-1:0]  gpio_prdata;
	logic               gpio_pready;
	logic               gpio_pslverr;

	logic               sys_psel;
	logic [W_DATA-1:0]  sys_prdata;
	logic               sys_pready;
	logic               sys_pslverr;

	// ========================================================================
	// Instances
	// ========================================================================

	ahbl_to_apb inst_ahbl_to_apb (
		.clk         (clk),
		.reset       (reset),
		.haddr       (haddr),
		.hwrite      (hwrite),
		.htrans      (htrans),
		.hsize       (hsize),
		.hready      (hready),
		.hwdata      (hwdata),
		.hready_resp (hready_resp),
		.hresp       (hresp),
		.hrdata      (hrdata),
		.paddr       (bridge_paddr),
		.psel        (bridge_psel),
		.penable     (bridge_penable),
		.pwrite      (bridge_pwrite),
		.pwdata      (bridge_pwdata),
		.prdata      (bridge_prdata),
		.pready      (bridge_pready),
		.pslverr     (bridge_pslverr)
	);

	apb_splitter inst_apb_splitter (
		.paddr        (bridge_paddr),
		.psel         (bridge_psel),
		.prdata       (bridge_prdata),
		.pready       (bridge_pready),
		.pslverr      (bridge_pslverr),
		.psel_gpio    (gpio_psel),
		.psel_sys     (sys_psel),
		.prdata_gpio  (gpio_prdata),
		.prdata_sys   (sys_prdata),
		.pready_gpio  (gpio_pready),
		.pready_sys   (sys_pready),
		.pslverr_gpio (gpio_pslverr),
		.pslverr_sys  (sys_pslverr)
	);

	// Address, strobe and write data fan out to both peripherals
	gpio inst_gpio (
		.clk     (clk),
		.reset   (reset),
		.psel    (gpio_psel),
		.penable (bridge_penable),
		.pwrite  (bridge_pwrite),
		.paddr   (bridge_paddr),
		.pwdata  (bridge_pwdata),
		.prdata  (gpio_prdata),
		.pready  (gpio_pready),
		.pslverr (gpio_pslverr),
		.pad_in  (pad_in),
		.pad_out (pad_out),
		.pad_oe  (pad_oe)
	);

	sys_ctrl inst_sys_ctrl (
		.clk     (clk),
		.reset   (reset),
		.psel    (sys_psel),
		.penable (bridge_penable),
		.pwrite  (bridge_pwrite),
		.paddr   (bridge_paddr),
		.pwdata  (bridge_pwdata),
		.prdata  (sys_prdata),
		.pready  (sys_pready),
		.pslverr (sys_pslverr)
	);

endmodule

//--- sys_ctrl/sys_ctrl.sv
// System control block with a read-only ID word and four scratch registers
`timescale 1ns/1ps

module sys_ctrl (
	input  logic                            clk,
	input  logic                            reset,
	input  logic                            psel,
	input  logic                            penable,
	input  logic                            pwrite,
	input  logic [riscboy_pkg::W_PADDR-1:0] paddr,
	input  logic [riscboy_pkg::W_DATA-1:0]  pwdata,
	output logic [riscboy_pkg::W_DATA-1:0]  prdata,
	output logic                            pready,
	output logic                            pslverr
);

	import riscboy_pkg::*;

	logic [W_DATA-1:0] scratch [0:3];

	logic [W_OFFS-1:0] offs;
	logic [1:0]        idx;
	logic              hit_id;
	logic              hit_scratch;

	assign offs   = paddr[W_OFFS-1:0];
	assign idx    = offs[3:2];
	assign hit_id = (offs == SYS_ID);
	// Word aligned offsets 0x10 to 0x1C
	assign hit_scratch = (offs[W_OFFS-1:4] == SYS_SCRATCH0[W_OFFS-1:4]) && (offs[1:0] == 2'b00);

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 4; i++)
				scratch[i] <= '0;
		end else if (psel && penable && pwrite && hit_scratch) begin
			scratch[idx] <= pwdata;
		end
	end

	always_comb begin
		if (hit_id)
			prdata = SYS_ID_VALUE;
		else if (hit_scratch)
			prdata = scratch[idx];
		else
			prdata = '0;
	end

	assign pready  = 1'b1;
	assign pslverr = psel && ((hit_id && pwrite) || !(hit_id || hit_scratch));

endmodule

//--- gpio/gpio.sv
// GPIO block with output and direction registers and a two-flop input synchronizer
`timescale 1ns/1ps

module gpio (
	input  logic                            clk,
	input  logic                            reset,
	input  logic                            psel,
	input  logic                            penable,
	input  logic                            pwrite,
	input  logic [riscboy_pkg::W_PADDR-1:0] paddr,
	input  logic [riscboy_pkg::W_DATA-1:0]  pwdata,
	output logic [riscboy_pkg::W_DATA-1:0]  prdata,
	output logic                            pready,
	output logic                            pslverr,
	input  logic [riscboy_pkg::N_PADS-1:0]  pad_in,
	output logic [riscboy_pkg::N_PADS-1:0]  pad_out,
	output logic [riscboy_pkg::N_PADS-1:0]  pad_oe
);

	import riscboy_pkg::*;

	logic [N_PADS-1:0] out_q;
	logic [N_PADS-1:0] dir_q;
	logic [N_PADS-1:0] in_meta;
	logic [N_PADS-1:0] in_sync;

	logic [W_OFFS-1:0] offs;
	logic              hit_out;
	logic              hit_dir;
	logic              hit_in;
	logic              wr_en;

	assign offs    = paddr[W_OFFS-1:0];
	assign hit_out = (offs == GPIO_OUT);
	assign hit_dir = (offs == GPIO_DIR);
	assign hit_in  = (offs == GPIO_IN);
	assign wr_en   = psel && penable && pwrite;

	// ========================================================================
	// Registers
	// ========================================================================

	always_ff @(posedge clk) begin
		if (reset) begin
			out_q <= '0;
			dir_q <= '0;
		end else if (wr_en) begin
			if (hit_out)
				out_q <= pwdata[N_PADS-1:0];
			if (hit_dir)
				dir_q <= pwdata[N_PADS-1:0];
		end
	end

	// Pads are asynchronous to clk
	always_ff @(posedge clk) begin
		in_meta <= pad_in;
		in_sync <= in_meta;
	end

	assign pad_out = out_q;
	assign pad_oe  = dir_q;

	// ========================================================================
	// APB response
	// ========================================================================

	always_comb begin
		prdata = '0;
		if (hit_out)
			prdata[N_PADS-1:0] = out_q;
		else if (hit_dir)
			prdata[N_PADS-1:0] = dir_q;
		else if (hit_in)
			prdata[N_PADS-1:0] = in_sync;
	end

	assign pready = 1'b1;
	// Input register is read-only
	assign pslverr = psel && ((pwrite && hit_in) || !(hit_out || hit_dir || hit_in));

endmodule

//--- verilog/apb_splitter.sv
// APB address splitter with peripheral selects, read mux and unmapped slot error
`timescale 1ns/1ps

module apb_splitter (
	input  logic [riscboy_pkg::W_PADDR-1:0] paddr,
	input  logic                            psel,
	output logic [riscboy_pkg::W_DATA-1:0]  prdata,
	output logic                            pready,
	output logic                            pslverr,
	output logic                            psel_gpio,
	output logic                            psel_sys,
	input  logic [riscboy_pkg::W_DATA-1:0]  prdata_gpio,
	input  logic [riscboy_pkg::W_DATA-1:0]  prdata_sys,
	input  logic                            pready_gpio,
	input  logic                            pready_sys,
	input  logic                            pslverr_gpio,
	input  logic                            pslverr_sys
);

	import riscboy_pkg::*;

	logic [W_PADDR-W_OFFS-1:0] slot;

	assign slot = paddr[W_PADDR-1:W_OFFS];

	assign psel_gpio = psel && (slot == SLOT_GPIO);
	assign psel_sys  = psel && (slot == SLOT_SYSCTRL);

	// Response of the selected peripheral
	always_comb begin
		case (slot)
			SLOT_GPIO: begin
				prdata  = prdata_gpio;
				pready  = pready_gpio;
				pslverr = pslverr_gpio;
			end
			SLOT_SYSCTRL: begin
				prdata  = prdata_sys;
				pready  = pready_sys;
				pslverr = pslverr_sys;
			end
			default: begin
				// Nobody lives here, answer at once with an error
				prdata  = '0;
				pready  = 1'b1;
				pslverr = 1'b1;
			end
		endcase
	end

	a_sel_onehot: assert final ($onehot0({psel_gpio, psel_sys}));

endmodule

//--- verilog/ahbl_to_apb.sv
// AHB-Lite slave to APB master bridge with transfer FSM and two-cycle error response
`timescale 1ns/1ps

module ahbl_to_apb (
	input  logic                             clk,
	input  logic                             reset,
	input  logic [riscboy_pkg::W_ADDR-1:0]   haddr,
	input  logic                             hwrite,
	input  logic [1:0]                       htrans,
	input  logic [2:0]                       hsize,
	input  logic                             hready,
	input  logic [riscboy_pkg::W_DATA-1:0]   hwdata,
	output logic                             hready_resp,
	output logic                             hresp,
	output logic [riscboy_pkg::W_DATA-1:0]   hrdata,
	output logic [riscboy_pkg::W_PADDR-1:0]  paddr,
	output logic                             psel,
	output logic                             penable,
	output logic                             pwrite,
	output logic [riscboy_pkg::W_DATA-1:0]   pwdata,
	input  logic [riscboy_pkg::W_DATA-1:0]   prdata,
	input  logic                             pready,
	input  logic                             pslverr
);

	import riscboy_pkg::*;

	bridge_state_t state;
	bridge_state_t state_nxt;

	logic [W_PADDR-1:0] addr_q;
	logic               write_q;
	logic [W_DATA-1:0]  wdata_q;
	logic [W_DATA-1:0]  rdata_q;

	logic addr_valid;
	logic size_ok;
	logic can_accept;

	assign addr_valid = hready && (htrans == HTRANS_NONSEQ);
	assign size_ok    = (hsize == HSIZE_WORD);
	// New address phases are taken in any cycle that ends a data phase
	assign can_accept = (state == IDLE) || (state == ERR2);

	// ========================================================================
	// Transfer FSM
	// ========================================================================

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE, ERR2: begin
				if (addr_valid)
					state_nxt = size_ok ? SETUP : ERR1;
				else
					state_nxt = IDLE;
			end
			SETUP: state_nxt = ACCESS;
			ACCESS: begin
				if (pready)
					state_nxt = pslverr ? ERR1 : IDLE;
			end
			ERR1: state_nxt = ERR2;
			default: state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset)
			state <= IDLE;
		else
			state <= state_nxt;
	end

	// Address phase, write data and read data capture
	always_ff @(posedge clk) begin
		if (can_accept && addr_valid) begin
			addr_q  <= haddr[W_PADDR-1:0];
			write_q <= hwrite;
		end
		if (state == SETUP)
			wdata_q <= hwdata;
		if (state == ACCESS && pready)
			rdata_q <= prdata;
	end

	// ========================================================================
	// Outputs
	// ========================================================================

	assign psel    = (state == SETUP) || (state == ACCESS);
	assign penable = (state == ACCESS);
	assign paddr   = addr_q;
	assign pwrite  = write_q;
	// hwdata goes straight out in setup, then the captured copy holds it
	assign pwdata  = (state == SETUP) ? hwdata : wdata_q;

	assign hready_resp = can_accept;
	assign hresp       = (state == ERR1) || (state == ERR2);
	assign hrdata      = rdata_q;

	// An access cycle is always preceded by the setup cycle of its transfer
	a_penable_psel: assert property (@(posedge clk) disable iff (reset)
		penable |-> psel && $past(psel));

	// First error cycle stalls the bus, the second one ends the data phase
	a_hresp_err: assert property (@(posedge clk) disable iff (reset)
		hresp && !hready_resp |=> hresp && hready_resp);

endmodule

//--- common/riscboy_pkg.sv
// Shared widths, address map, register offsets and bridge states of the peripheral subsystem
package riscboy_pkg;

	// ========================================================================
	// Bus widths
	// ========================================================================

	localparam int W_ADDR  = 32;
	localparam int W_DATA  = 32;
	localparam int W_PADDR = 16;
	// Low APB address bits that select a register inside one peripheral
	localparam int W_OFFS  = 12;
	localparam int N_PADS  = 16;

	// ========================================================================
	// Address map
	// ========================================================================

	localparam logic [W_ADDR-1:0] APB_BASE = 32'h4000_0000;

	// Top nibble of the APB address
	localparam logic [W_PADDR-W_OFFS-1:0] SLOT_GPIO    = 4'h0;
	localparam logic [W_PADDR-W_OFFS-1:0] SLOT_SYSCTRL = 4'h1;

	// GPIO registers
	localparam logic [W_OFFS-1:0] GPIO_OUT = 12'h000;
	localparam logic [W_OFFS-1:0] GPIO_DIR = 12'h004;
	localparam logic [W_OFFS-1:0] GPIO_IN  = 12'h008;

	// System control registers, scratch words at 0x10 to 0x1C
	localparam logic [W_OFFS-1:0] SYS_ID       = 12'h000;
	localparam logic [W_OFFS-1:0] SYS_SCRATCH0 = 12'h010;

	localparam logic [W_DATA-1:0] SYS_ID_VALUE = 32'h5242_0001;

	// ========================================================================
	// AHB-Lite codes and bridge states
	// ========================================================================

	localparam logic [1:0] HTRANS_IDLE   = 2'b00;
	localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
	localparam logic [2:0] HSIZE_WORD    = 3'b010;

	typedef enum logic [2:0] {
		IDLE,
		SETUP,
		ACCESS,
		ERR1,
		ERR2
	} bridge_state_t;

endpackage
